// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module dcacheTb -f src.f -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "test did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/dcacheCtrl_props.sv
`default_nettype none

module dcacheCtrlProps (
  input logic clk,
  input logic rst_n,
  input logic addrOk_o,
  input logic dataOk_o,
  input logic busRdValid_o,
  input logic busRdReady_i,
  input logic busWrValid_o,
  input logic busWrReady_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // bus requests stay up until memory takes them
  rdValidHeld: assert property (@(posedge clk) disable iff (!rst_n)
    busRdValid_o && !busRdReady_i |=> busRdValid_o)
    else $error("bus read request dropped before it was accepted");

  wrValidHeld: assert property (@(posedge clk) disable iff (!rst_n)
    busWrValid_o && !busWrReady_i |=> busWrValid_o)
    else $error("bus write request dropped before it was accepted");

  // completion is a single-cycle pulse
  dataOkPulse: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_o |=> !dataOk_o)
    else $error("dataOk high in two consecutive cycles");

  idleNotWriting: assert property (@(posedge clk) disable iff (!rst_n)
    !(addrOk_o && busWrValid_o))
    else $error("addrOk and busWrValid high together");

endmodule

bind dcacheCtrl dcacheCtrlProps ctrlProps (
  .clk(clk),
  .rst_n(rst_n),
  .addrOk_o(addrOk_o),
  .dataOk_o(dataOk_o),
  .busRdValid_o(busRdValid_o),
  .busRdReady_i(busRdReady_i),
  .busWrValid_o(busWrValid_o),
  .busWrReady_i(busWrReady_i)
);

`default_nettype wire

// File: bench/dcacheTb.sv
`default_nettype none

module dcacheTb;
  timeunit 1ns;
  timeprecision 100ps;
  import dcachePkg::*;
  import busPkg::*;

  // worst case is about 25 cycles for each of roughly 410 requests
  localparam int TimeoutCycles  = 12000;
  localparam int RandomRequests = 400;

  logic      clk = 1'b0;
  logic      rst_n;
  cpuReq_t   req_i;
  logic      reqValid_i;
  logic      addrOk_o;
  logic      dataOk_o;
  word_t     rdData_o;
  logic      busRdValid_o;
  addr_t     busRdAddr_o;
  logic      busRdReady_i;
  word_t     busData_i;
  logic      busDataValid_i;
  logic      busLast_i;
  busWrReq_t busWr_o;
  logic      busWrValid_o;
  logic      busWrReady_i;

  // memory and shadow copy keyed by word address
  word_t  memArr [addr_t];
  word_t  shadowArr [addr_t];
  word_t  expData;
  logic   pendingLoad = 1'b0;
  string  testName = "reset";
  int     rdCount = 0;
  int     wrCount = 0;
  int     cycleCount = 0;
  addr_t  lastRdAddr;
  tag_t   tagList [3] = '{21'h00a5c, 21'h1f3e1, 21'h07777};
  index_t setList [4] = '{6'd3, 6'd17, 6'd33, 6'd58};

  dcache uut (.*);

  always #5 clk = ~clk;

  function automatic word_t initialWord(addr_t wordAddr);
    return {wordAddr ^ 32'hc0de_0000, ~(wordAddr * 32'h9e37_79b9)};
  endfunction

  function automatic word_t readMem(addr_t wordAddr);
    return memArr.exists(wordAddr) ? memArr[wordAddr] : initialWord(wordAddr);
  endfunction

  // expected word of a request after merging any store into the shadow
  function automatic word_t refAccess(cpuReq_t r);
    addr_t wordAddr;
    word_t cur;
    wordAddr = r.addr >> 3;
    cur = shadowArr.exists(wordAddr) ? shadowArr[wordAddr] : initialWord(wordAddr);
    if (r.op == opStore) begin
      for (int b = 0; b < 8; b++) begin
        if (r.wmask[b]) cur[b*8 +: 8] = r.wdata[b*8 +: 8];
      end
      shadowArr[wordAddr] = cur;
    end
    return cur;
  endfunction

  function automatic addr_t makeAddr(tag_t tag, index_t index, logic [1:0] wordSel);
    return {tag, index, wordSel, 3'b000};
  endfunction

  task automatic stopWithFailure(string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValue(string what, word_t expected, word_t actual);
    assert (expected === actual) else
      stopWithFailure($sformatf("Mismatch in %s (%s): expected %h, actual %h",
                                testName, what, expected, actual));
  endtask

  // one request from idle to dataOk with latency counted from acceptance
  task automatic runRequest(memOp_e reqOp, addr_t reqAddr, word_t reqData,
                            byteMask_t reqMask, output int latency);
    cpuReq_t r;
    r = '{reqOp, reqAddr, reqData, reqMask};
    @(negedge clk);
    while (!addrOk_o) @(negedge clk);
    expData = refAccess(r);
    pendingLoad = (reqOp == opLoad);
    @(posedge clk);
    req_i <= r;
    reqValid_i <= 1'b1;
    @(posedge clk);
    reqValid_i <= 1'b0;
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
    end while (!dataOk_o);
    // load compare at this dataOk finishes before the caller moves on
    @(posedge clk);
  endtask

  always @(negedge clk) begin
    if (dataOk_o && pendingLoad) checkValue("load data", expData, rdData_o);
  end

  always @(posedge clk) begin
    cycleCount++;
    assert (cycleCount < TimeoutCycles) else
      stopWithFailure($sformatf("Timeout: run not done after %0d cycles", TimeoutCycles));
  end

  // write side of memory takes the line in the handshake cycle
  initial begin : writeResponder
    busWrReq_t wr;
    busWrReady_i = 1'b0;
    forever begin
      @(negedge clk);
      if (busWrValid_o) begin
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        busWrReady_i <= 1'b1;
        @(negedge clk);
        if (busWrValid_o) begin
          wr = busWr_o;
          wrCount++;
          for (int w = 0; w < BeatsPerLine; w++) begin
            memArr[(wr.addr >> 3) + w] = wr.line[w*WordBits +: WordBits];
          end
        end
        @(posedge clk);
        busWrReady_i <= 1'b0;
      end
    end
  end

  initial begin : readResponder
    addr_t lineAddr;
    busRdReady_i = 1'b0;
    busDataValid_i = 1'b0;
    busLast_i = 1'b0;
    busData_i = '0;
    forever begin
      @(negedge clk);
      if (busRdValid_o) begin
        lineAddr = busRdAddr_o;
        lastRdAddr = lineAddr;
        rdCount++;
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        busRdReady_i <= 1'b1;
        @(posedge clk);
        busRdReady_i <= 1'b0;
        for (int beat = 0; beat < BeatsPerLine; beat++) begin
          // gaps between beats
          repeat ($urandom_range(2, 0)) begin
            @(posedge clk);
            busDataValid_i <= 1'b0;
            busLast_i <= 1'b0;
          end
          @(posedge clk);
          busDataValid_i <= 1'b1;
          busData_i <= readMem((lineAddr >> 3) + beat);
          busLast_i <= (beat == BeatsPerLine - 1);
        end
        @(posedge clk);
        busDataValid_i <= 1'b0;
        busLast_i <= 1'b0;
      end
    end
  end

  initial begin : mainSequence
    int    lat;
    int    rdBefore;
    int    wrBefore;
    addr_t a;
    void'($urandom(32'h176d));
    rst_n = 1'b0;
    reqValid_i = 1'b0;
    req_i = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checkValue("addrOk, dataOk, busRdValid, busWrValid", word_t'(4'b1000),
               word_t'({addrOk_o, dataOk_o, busRdValid_o, busWrValid_o}));

    testName = "read miss";
    a = makeAddr(tagList[0], 6'd40, 2'd2);
    rdBefore = rdCount;
    runRequest(opLoad, a, '0, '0, lat);
    checkValue("bus reads", word_t'(rdBefore + 1), word_t'(rdCount));
    checkValue("read address", word_t'({a[31:5], 5'b0}), word_t'(lastRdAddr));

    testName = "hit latency";
    rdBefore = rdCount;
    wrBefore = wrCount;
    runRequest(opLoad, makeAddr(tagList[0], 6'd40, 2'd1), '0, '0, lat);
    checkValue("latency", word_t'(1), word_t'(lat));
    checkValue("bus requests", word_t'(rdBefore + wrBefore), word_t'(rdCount + wrCount));

    testName = "masked store";
    runRequest(opStore, a, 64'h1122_3344_5566_7788, 8'b1010_0101, lat);
    checkValue("store latency", word_t'(1), word_t'(lat));
    runRequest(opLoad, a, '0, '0, lat);

    // three tags in a 2-way set force dirty evictions
    testName = "eviction";
    wrBefore = wrCount;
    for (int t = 0; t < 3; t++) begin
      runRequest(opStore, makeAddr(tagList[t], 6'd41, 2'd0), {$urandom(), $urandom()},
                 8'hff, lat);
    end
    for (int t = 0; t < 3; t++) begin
      runRequest(opLoad, makeAddr(tagList[t], 6'd41, 2'd0), '0, '0, lat);
    end
    assert (wrCount > wrBefore) else
      stopWithFailure("Eviction test finished without any write-back of a dirty line");

    testName = "random traffic";
    for (int n = 0; n < RandomRequests; n++) begin
      a = makeAddr(tagList[$urandom_range(2, 0)], setList[$urandom_range(3, 0)],
                   2'($urandom_range(3, 0)));
      if ($urandom_range(1, 0) == 1) begin
        runRequest(opStore, a, {$urandom(), $urandom()}, byteMask_t'($urandom()), lat);
      end else begin
        runRequest(opLoad, a, '0, '0, lat);
      end
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/busPkg.sv
`default_nettype none

package busPkg;

  // one line moves as a burst of pipeline words
  localparam int BeatsPerLine  = dcachePkg::WordsPerLine;
  localparam int BeatCountBits = $clog2(BeatsPerLine);

  // write-back request, whole line at once
  typedef struct packed {
    dcachePkg::addr_t addr;
    dcachePkg::line_t line;
  } busWrReq_t;

endpackage

`default_nettype wire

// File: rtl/dataStore.sv
`default_nettype none

module dataStore (
  input  logic                 clk,
  input  dcachePkg::index_t    index_i,
  input  logic [1:0]           wordSel_i,
  input  logic                 hitWay_i,
  input  logic                 victimWay_i,
  input  logic                 storeEn_i,
  input  logic                 installEn_i,
  input  dcachePkg::word_t     wdata_i,
  input  dcachePkg::byteMask_t wmask_i,
  input  dcachePkg::line_t     fillLine_i,
  output dcachePkg::word_t     rdWord_o,
  output dcachePkg::line_t     victimLine_o
);
  import dcachePkg::*;

  line_t lineArr [NumWays][NumSets];
  line_t hitLine;

  // combinational read of both the hit and the victim line
  assign hitLine      = lineArr[hitWay_i][index_i];
  assign rdWord_o     = hitLine[wordSel_i*WordBits +: WordBits];
  assign victimLine_o = lineArr[victimWay_i][index_i];

  always_ff @(posedge clk) begin
    if (installEn_i) begin
      lineArr[victimWay_i][index_i] <= fillLine_i;
    end else if (storeEn_i) begin
      // only the enabled bytes of the selected word change
      for (int b = 0; b < WordBits/8; b++) begin
        if (wmask_i[b]) begin
          lineArr[hitWay_i][index_i][wordSel_i*WordBits + b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/dcache.sv
`default_nettype none

module dcache (
  input  logic               clk,
  input  logic               rst_n,
  input  dcachePkg::cpuReq_t req_i,
  input  logic               reqValid_i,
  output logic               addrOk_o,
  output logic               dataOk_o,
  output dcachePkg::word_t   rdData_o,
  output logic               busRdValid_o,
  output dcachePkg::addr_t   busRdAddr_o,
  input  logic               busRdReady_i,
  input  dcachePkg::word_t   busData_i,
  input  logic               busDataValid_i,
  input  logic               busLast_i,
  output busPkg::busWrReq_t  busWr_o,
  output logic               busWrValid_o,
  input  logic               busWrReady_i
);
  import dcachePkg::*;

  cpuReq_t curReq;
  logic    hit;
  logic    hitWay;
  logic    victimWay;
  logic    victimDirty;
  tag_t    victimTag;
  line_t   victimLine;
  line_t   fillLine;
  logic    storeEn;
  logic    installEn;
  logic    beatsEn;

  dcacheCtrl ctrl (
    .clk, .rst_n, .req_i, .reqValid_i,
    .hit_i(hit), .hitWay_i(hitWay), .victimDirty_i(victimDirty),
    .victimTag_i(victimTag), .victimLine_i(victimLine),
    .busRdReady_i, .busWrReady_i, .busLast_i, .busDataValid_i,
    .addrOk_o, .dataOk_o, .curReq_o(curReq),
    .storeEn_o(storeEn), .installEn_o(installEn), .beatsEn_o(beatsEn),
    .victimWay_o(victimWay),
    .busRdValid_o, .busRdAddr_o, .busWrValid_o, .busWr_o
  );

  tagStore tags (
    .clk, .rst_n,
    .index_i(curReq.addr[OffsetBits +: IndexBits]),
    .tag_i(curReq.addr[AddrWidth-1 -: TagBits]),
    .victimWay_i(victimWay), .storeEn_i(storeEn), .installEn_i(installEn),
    .hit_o(hit), .hitWay_o(hitWay),
    .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  // word select is the upper part of the line offset
  dataStore data (
    .clk,
    .index_i(curReq.addr[OffsetBits +: IndexBits]),
    .wordSel_i(curReq.addr[OffsetBits-1 -: 2]),
    .hitWay_i(hitWay), .victimWay_i(victimWay),
    .storeEn_i(storeEn), .installEn_i(installEn),
    .wdata_i(curReq.wdata), .wmask_i(curReq.wmask),
    .fillLine_i(fillLine),
    .rdWord_o(rdData_o), .victimLine_o(victimLine)
  );

  refillBuffer refill (
    .clk, .rst_n,
    .beatsEn_i(beatsEn), .busData_i, .busDataValid_i,
    .fillLine_o(fillLine)
  );

endmodule

`default_nettype wire

// File: rtl/dcacheCtrl.sv
`default_nettype none

module dcacheCtrl (
  input  logic                clk,
  input  logic                rst_n,
  input  dcachePkg::cpuReq_t  req_i,
  input  logic                reqValid_i,
  input  logic                hit_i,
  input  logic                hitWay_i,
  input  logic                victimDirty_i,
  input  dcachePkg::tag_t     victimTag_i,
  input  dcachePkg::line_t    victimLine_i,
  input  logic                busRdReady_i,
  input  logic                busWrReady_i,
  input  logic                busLast_i,
  input  logic                busDataValid_i,
  output logic                addrOk_o,
  output logic                dataOk_o,
  output dcachePkg::cpuReq_t  curReq_o,
  output logic                storeEn_o,
  output logic                installEn_o,
  output logic                beatsEn_o,
  output logic                victimWay_o,
  output logic                busRdValid_o,
  output dcachePkg::addr_t    busRdAddr_o,
  output logic                busWrValid_o,
  output busPkg::busWrReq_t   busWr_o
);
  import dcachePkg::*;

  cacheState_e state;
  cacheState_e nextState;
  logic        victimToggle;
  logic        refilled;
  logic        cmpHit;
  index_t      curIndex;

  assign curIndex = curReq_o.addr[OffsetBits +: IndexBits];

  // after a refill the answer must come from the way just installed,
  // which is the one the toggle pointed at before it flipped
  assign cmpHit = hit_i && (!refilled || (hitWay_i == ~victimToggle));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        if (reqValid_i) nextState = stCompare;
      end
      stCompare: begin
        if (cmpHit) begin
          nextState = stIdle;
        end else if (victimDirty_i) begin
          nextState = stWriteBack;
        end else begin
          nextState = stFetchReq;
        end
      end
      stWriteBack: begin
        if (busWrReady_i) nextState = stFetchReq;
      end
      stFetchReq: begin
        if (busRdReady_i) nextState = stRefill;
      end
      stRefill: begin
        // beats can arrive with gaps, wait for the last one
        if (busDataValid_i && busLast_i) nextState = stInstall;
      end
      stInstall: begin
        nextState = stCompare;
      end
      default: begin
        nextState = stIdle;
      end
    endcase
  end

  // request is captured only on acceptance
  always_ff @(posedge clk) begin
    if (addrOk_o && reqValid_i) begin
      curReq_o <= req_i;
    end
  end

  // round-robin victim, flips once per replacement
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimToggle <= 1'b0;
      refilled     <= 1'b0;
    end else if (state == stInstall) begin
      victimToggle <= ~victimToggle;
      refilled     <= 1'b1;
    end else if (state == stCompare) begin
      refilled     <= 1'b0;
    end
  end

  assign addrOk_o    = (state == stIdle);
  assign dataOk_o    = (state == stCompare) && cmpHit;
  assign storeEn_o   = dataOk_o && (curReq_o.op == opStore);
  assign installEn_o = (state == stInstall);
  assign beatsEn_o   = (state == stRefill);
  assign victimWay_o = victimToggle;

  // fetch the whole line that holds the request
  assign busRdValid_o = (state == stFetchReq);
  assign busRdAddr_o  = {curReq_o.addr[AddrWidth-1:OffsetBits], OffsetBits'(0)};

  // victim address is rebuilt from its stored tag
  assign busWrValid_o = (state == stWriteBack);
  assign busWr_o      = '{addr: {victimTag_i, curIndex, OffsetBits'(0)},
                          line: victimLine_i};

endmodule

`default_nettype wire

// File: rtl/dcachePkg.sv
`default_nettype none

package dcachePkg;

  // geometry of the 2-way write-back cache
  localparam int AddrWidth    = 32;
  localparam int WordBits     = 64;
  localparam int WordsPerLine = 4;
  localparam int LineBits     = WordBits * WordsPerLine;
  localparam int NumSets      = 64;
  localparam int NumWays      = 2;
  localparam int OffsetBits   = $clog2(LineBits / 8);
  localparam int IndexBits    = $clog2(NumSets);
  localparam int TagBits      = AddrWidth - IndexBits - OffsetBits;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [WordBits-1:0]     word_t;
  typedef logic [LineBits-1:0]     line_t;
  typedef logic [TagBits-1:0]      tag_t;
  typedef logic [IndexBits-1:0]    index_t;
  typedef logic [WordBits/8-1:0]   byteMask_t;

  typedef enum logic {
    opLoad,
    opStore
  } memOp_e;

  // 1 + 32 + 64 + 8 = 105 bits
  typedef struct packed {
    memOp_e    op;
    addr_t     addr;
    word_t     wdata;
    byteMask_t wmask;
  } cpuReq_t;

  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stWriteBack,
    stFetchReq,
    stRefill,
    stInstall
  } cacheState_e;

endpackage

`default_nettype wire

// File: rtl/refillBuffer.sv
`default_nettype none

module refillBuffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             beatsEn_i,
  input  dcachePkg::word_t busData_i,
  input  logic             busDataValid_i,
  output dcachePkg::line_t fillLine_o
);
  import dcachePkg::*;
  import busPkg::*;

  logic [BeatCountBits-1:0] beatCnt;

  // counter restarts for every refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (!beatsEn_i) begin
      beatCnt <= '0;
    end else if (busDataValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // beats fill the line from word 0 upward
  always_ff @(posedge clk) begin
    if (beatsEn_i && busDataValid_i) begin
      fillLine_o[beatCnt*WordBits +: WordBits] <= busData_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/tagStore.sv
`default_nettype none

module tagStore (
  input  logic              clk,
  input  logic              rst_n,
  input  dcachePkg::index_t index_i,
  input  dcachePkg::tag_t   tag_i,
  input  logic              victimWay_i,
  input  logic              storeEn_i,
  input  logic              installEn_i,
  output logic              hit_o,
  output logic              hitWay_o,
  output logic              victimDirty_o,
  output dcachePkg::tag_t   victimTag_o
);
  import dcachePkg::*;

  tag_t                             tagArr [NumWays][NumSets];
  logic [NumWays-1:0][NumSets-1:0]  validArr;
  logic [NumWays-1:0][NumSets-1:0]  dirtyArr;
  logic [NumWays-1:0]               wayHit;

  // compare both ways in parallel
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayHit[w] = validArr[w][index_i] && (tagArr[w][index_i] == tag_i);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // an invalid way never needs a write-back
  assign victimDirty_o = validArr[victimWay_i][index_i] && dirtyArr[victimWay_i][index_i];
  assign victimTag_o   = tagArr[victimWay_i][index_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      dirtyArr <= '0;
    end else if (installEn_i) begin
      // fresh line from memory is clean
      validArr[victimWay_i][index_i] <= 1'b1;
      dirtyArr[victimWay_i][index_i] <= 1'b0;
    end else if (storeEn_i) begin
      dirtyArr[hitWay_o][index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (installEn_i) begin
      tagArr[victimWay_i][index_i] <= tag_i;
    end
  end

endmodule

`default_nettype wire

// File: src.f
rtl/dcachePkg.sv
rtl/busPkg.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/refillBuffer.sv
rtl/dcacheCtrl.sv
rtl/dcache.sv
bench/dcacheCtrl_props.sv
bench/dcacheTb.sv
